// ==== miss_cache_pkg.sv ====
package miss_cache_pkg;

    // Core and memory interface widths
    parameter int LINE_ADDR_WIDTH = 16;
    parameter int WORD_SEL_WIDTH  = 2;
    parameter int WORD_WIDTH      = 32;
    parameter int CORE_TAG_WIDTH  = 8;

    // Core request as it arrives from the core and waits in a bank queue
    typedef struct packed {
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        logic [WORD_SEL_WIDTH-1:0]  word_sel;
        logic                       write;
        logic [WORD_WIDTH-1:0]      data;
        logic [CORE_TAG_WIDTH-1:0]  tag;
    } core_req_t;

    // Core response, no data path in this model
    typedef struct packed {
        logic [CORE_TAG_WIDTH-1:0]  tag;
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        logic                       write;
        // Set when the answer was replayed from the miss queue
        logic                       replay;
    } core_rsp_t;

    // Fill request to memory and fill return from memory
    typedef struct packed {
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
    } fill_t;

    // Bank index is the low bits of the line address
    // Bank count must be a power of two
    function automatic int unsigned bank_of(
        input logic [LINE_ADDR_WIDTH-1:0] line_addr,
        input int unsigned                num_banks
    );
        int unsigned addr;
        addr = int'(line_addr);
        return addr % num_banks;
    endfunction

    // Slot index sits just above the bank bits
    // Set count must be a power of two as well
    function automatic int unsigned slot_of(
        input logic [LINE_ADDR_WIDTH-1:0] line_addr,
        input int unsigned                num_banks,
        input int unsigned                sets_per_bank
    );
        int unsigned addr;
        addr = int'(line_addr);
        return (addr / num_banks) % sets_per_bank;
    endfunction

endpackage

// ==== req_dispatch.sv ====
`timescale 1ns/1ns

module req_dispatch #(
    parameter int NUM_BANKS = 4
) (
    input  logic                    clk,
    input  logic                    reset,

    // Core side
    input  logic                    req_valid,
    input  miss_cache_pkg::core_req_t req,
    output logic                    req_stall,

    // Bank side
    input  logic [NUM_BANKS-1:0]    bank_stop,
    output logic [NUM_BANKS-1:0]    bank_req_valid,
    output miss_cache_pkg::core_req_t bank_req
);

    localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [BANK_W-1:0] target;
    logic              target_stop;

    // Bank select straight from the low line address bits
    assign target = BANK_W'(miss_cache_pkg::bank_of(req.line_addr, NUM_BANKS));

    assign target_stop = bank_stop[target];

    // Stall is a level, held whatever req_valid does
    assign req_stall = target_stop;

    // Payload fans out to every bank, only the valid is steered
    assign bank_req = req;

    always_comb begin
        bank_req_valid = '0;
        if (req_valid && !target_stop) begin
            bank_req_valid[target] = 1'b1;
        end
    end

endmodule

// ==== miss_resrv.sv ====
`timescale 1ns/1ns

module miss_resrv #(
    parameter int MRVQ_SIZE = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,

    // Enqueue
    input  logic                                        push,
    input  miss_cache_pkg::core_req_t                   push_req,
    output logic                                        full,
    output logic                                        stop,
    output logic                                        empty,

    // Fill broadcast, wakes every entry waiting on the line
    input  logic                                        fill_hit,
    input  logic [miss_cache_pkg::LINE_ADDR_WIDTH-1:0]  fill_addr,

    // In-order dequeue
    input  logic                                        pop,
    output logic                                        head_valid,
    output miss_cache_pkg::core_req_t                   head_req,

    // Outstanding line lookup
    input  logic [miss_cache_pkg::LINE_ADDR_WIDTH-1:0]  match_addr,
    output logic                                        match
);

    localparam int PTR_W = $clog2(MRVQ_SIZE);
    localparam int CNT_W = $clog2(MRVQ_SIZE + 1);

    miss_cache_pkg::core_req_t req_table [MRVQ_SIZE];

    logic [MRVQ_SIZE-1:0] valid_table;
    logic [MRVQ_SIZE-1:0] ready_table;
    logic [MRVQ_SIZE-1:0] make_ready;
    logic [MRVQ_SIZE-1:0] waiting_on;
    logic [PTR_W-1:0]     head_ptr;
    logic [PTR_W-1:0]     tail_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_push;
    logic                 do_pop;
    logic                 push_ready;

    assign full  = (count == CNT_W'(MRVQ_SIZE));
    assign empty = (count == '0);

    // Early stop leaves a few entries for requests already on their way
    assign stop = (count > CNT_W'(MRVQ_SIZE - 3));

    always_comb begin
        for (int e = 0; e < MRVQ_SIZE; e++) begin
            make_ready[e] = fill_hit && valid_table[e] &&
                            (req_table[e].line_addr == fill_addr);
            waiting_on[e] = valid_table[e] && !ready_table[e] &&
                            (req_table[e].line_addr == match_addr);
        end
    end

    assign match = |waiting_on;

    // Only the oldest entry may leave, and only once its line is in
    assign head_valid = valid_table[head_ptr] && ready_table[head_ptr];
    assign head_req   = req_table[head_ptr];

    assign do_push = push && !full;
    assign do_pop  = pop && head_valid;

    // An entry pushed while its line is being woken starts out ready
    assign push_ready = fill_hit && (push_req.line_addr == fill_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_table <= '0;
            ready_table <= '0;
            head_ptr    <= '0;
            tail_ptr    <= '0;
            count       <= '0;
        end else begin
            ready_table <= ready_table | make_ready;

            if (do_push) begin
                valid_table[tail_ptr] <= 1'b1;
                ready_table[tail_ptr] <= push_ready;
                tail_ptr <= (tail_ptr == PTR_W'(MRVQ_SIZE - 1)) ? '0 : tail_ptr + 1'b1;
            end

            if (do_pop) begin
                valid_table[head_ptr] <= 1'b0;
                ready_table[head_ptr] <= 1'b0;
                head_ptr <= (head_ptr == PTR_W'(MRVQ_SIZE - 1)) ? '0 : head_ptr + 1'b1;
            end

            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (do_push) begin
            req_table[tail_ptr] <= push_req;
        end
    end

endmodule

// ==== cache_bank.sv ====
`timescale 1ns/1ns

module cache_bank #(
    parameter int BANK_INDEX    = 0,
    parameter int NUM_BANKS     = 4,
    parameter int MRVQ_SIZE     = 8,
    parameter int SETS_PER_BANK = 16
) (
    input  logic                      clk,
    input  logic                      reset,

    // Request from the dispatcher
    input  logic                      req_valid,
    input  miss_cache_pkg::core_req_t req,
    output logic                      stop,

    // Fill broadcast from memory
    input  logic                      fill_valid,
    input  miss_cache_pkg::fill_t     fill,

    // Toward the drain
    output logic                      rsp_pend,
    output miss_cache_pkg::core_rsp_t rsp,
    input  logic                      rsp_grant,
    output logic                      fill_pend,
    output miss_cache_pkg::fill_t     fill_req,
    input  logic                      fill_grant
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int SLOT_BITS = $clog2(SETS_PER_BANK);
    localparam int SLOT_W    = (SLOT_BITS > 0) ? SLOT_BITS : 1;
    localparam int TAG_W     = miss_cache_pkg::LINE_ADDR_WIDTH - BANK_BITS - SLOT_BITS;

    logic [SETS_PER_BANK-1:0] present;
    logic [TAG_W-1:0]         tag_table [SETS_PER_BANK];

    logic [SLOT_W-1:0] req_slot;
    logic [SLOT_W-1:0] fill_slot;
    logic [TAG_W-1:0]  req_tag;
    logic [TAG_W-1:0]  fill_tag;
    logic              line_present;
    logic              fill_mine;
    logic              rsp_free;
    logic              hit;
    logic              push;
    logic              pop;
    logic              need_fill;

    // Queue side
    logic                      q_full;
    logic                      q_stop;
    logic                      q_empty;
    logic                      q_wake;
    logic [miss_cache_pkg::LINE_ADDR_WIDTH-1:0] q_wake_addr;
    logic                      q_head_valid;
    miss_cache_pkg::core_req_t q_head_req;
    logic                      q_match;

    assign req_slot  = SLOT_W'(miss_cache_pkg::slot_of(req.line_addr, NUM_BANKS, SETS_PER_BANK));
    assign fill_slot = SLOT_W'(miss_cache_pkg::slot_of(fill.line_addr, NUM_BANKS, SETS_PER_BANK));
    assign req_tag   = TAG_W'(req.line_addr >> (BANK_BITS + SLOT_BITS));
    assign fill_tag  = TAG_W'(fill.line_addr >> (BANK_BITS + SLOT_BITS));

    assign line_present = present[req_slot] && (tag_table[req_slot] == req_tag);
    assign fill_mine    = fill_valid &&
                          (miss_cache_pkg::bank_of(fill.line_addr, NUM_BANKS) == BANK_INDEX);

    // Response register frees up on the same edge it is granted
    assign rsp_free = !rsp_pend || rsp_grant;

    // Anything queued forces later requests in behind it
    assign hit       = req_valid && line_present && q_empty && rsp_free;
    assign push      = req_valid && !hit && !q_full;
    assign need_fill = push && !line_present && !q_match;
    assign pop       = q_head_valid && rsp_free;

    // A fill cycle closes the input so the wake path is free for the fill
    assign stop = q_stop || fill_pend || fill_mine;

    // Present lines that queue up wake themselves on the way in
    assign q_wake      = fill_mine || (push && line_present);
    assign q_wake_addr = fill_mine ? fill.line_addr : req.line_addr;

    miss_resrv #(
        .MRVQ_SIZE (MRVQ_SIZE)
    ) i_miss_resrv (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_req   (req),
        .full       (q_full),
        .stop       (q_stop),
        .empty      (q_empty),
        .fill_hit   (q_wake),
        .fill_addr  (q_wake_addr),
        .pop        (pop),
        .head_valid (q_head_valid),
        .head_req   (q_head_req),
        .match_addr (req.line_addr),
        .match      (q_match)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_pend  <= 1'b0;
            fill_pend <= 1'b0;
            present   <= '0;
        end else begin
            if (hit || pop) begin
                rsp_pend <= 1'b1;
            end else if (rsp_grant) begin
                rsp_pend <= 1'b0;
            end
            if (need_fill) begin
                fill_pend <= 1'b1;
            end else if (fill_grant) begin
                fill_pend <= 1'b0;
            end
            // A fill simply takes over the slot
            if (fill_mine) begin
                present[fill_slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rsp <= '{tag: req.tag, line_addr: req.line_addr, write: req.write, replay: 1'b0};
        end else if (pop) begin
            rsp <= '{tag: q_head_req.tag, line_addr: q_head_req.line_addr,
                     write: q_head_req.write, replay: 1'b1};
        end
        if (need_fill) begin
            fill_req.line_addr <= req.line_addr;
        end
        if (fill_mine) begin
            tag_table[fill_slot] <= fill_tag;
        end
    end

endmodule

// ==== bank_drain.sv ====
`timescale 1ns/1ns

module bank_drain #(
    parameter int NUM_BANKS = 4
) (
    input  logic                      clk,
    input  logic                      reset,

    // Bank responses
    input  logic [NUM_BANKS-1:0]      rsp_pend,
    input  miss_cache_pkg::core_rsp_t bank_rsp [NUM_BANKS],
    output logic [NUM_BANKS-1:0]      rsp_grant,

    // Bank fill requests
    input  logic [NUM_BANKS-1:0]      fill_pend,
    input  miss_cache_pkg::fill_t     bank_fill [NUM_BANKS],
    output logic [NUM_BANKS-1:0]      fill_grant,

    // Merged outputs, one-cycle pulses
    output logic                      rsp_valid,
    output miss_cache_pkg::core_rsp_t rsp,
    output logic                      fill_req_valid,
    output miss_cache_pkg::fill_t     fill_req
);

    localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [BANK_W-1:0] rsp_last;
    logic [BANK_W-1:0] rsp_win;
    logic              rsp_any;
    logic [BANK_W-1:0] fill_last;
    logic [BANK_W-1:0] fill_win;
    logic              fill_any;

    // First pending bank after the last winner, wrapping around
    function automatic logic [BANK_W-1:0] rr_pick(
        input logic [NUM_BANKS-1:0] pend,
        input logic [BANK_W-1:0]    last
    );
        logic [BANK_W-1:0] idx;
        logic [BANK_W-1:0] win;
        logic              found;
        win   = last;
        found = 1'b0;
        for (int k = 1; k <= NUM_BANKS; k++) begin
            idx = BANK_W'((int'(last) + k) % NUM_BANKS);
            if (!found && pend[idx]) begin
                win   = idx;
                found = 1'b1;
            end
        end
        return win;
    endfunction

    assign rsp_any  = |rsp_pend;
    assign fill_any = |fill_pend;
    assign rsp_win  = rr_pick(rsp_pend, rsp_last);
    assign fill_win = rr_pick(fill_pend, fill_last);

    always_comb begin
        rsp_grant  = '0;
        fill_grant = '0;
        if (rsp_any) begin
            rsp_grant[rsp_win] = 1'b1;
        end
        if (fill_any) begin
            fill_grant[fill_win] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid      <= 1'b0;
            fill_req_valid <= 1'b0;
            rsp_last       <= BANK_W'(NUM_BANKS - 1);
            fill_last      <= BANK_W'(NUM_BANKS - 1);
        end else begin
            rsp_valid      <= rsp_any;
            fill_req_valid <= fill_any;
            if (rsp_any) begin
                rsp_last <= rsp_win;
            end
            if (fill_any) begin
                fill_last <= fill_win;
            end
        end
    end

    always_ff @(posedge clk) begin
        rsp      <= bank_rsp[rsp_win];
        fill_req <= bank_fill[fill_win];
    end

endmodule

// ==== miss_cache_top.sv ====
`timescale 1ns/1ns

module miss_cache_top #(
    parameter int NUM_BANKS     = 4,
    parameter int MRVQ_SIZE     = 8,
    parameter int SETS_PER_BANK = 16
) (
    input  logic                      clk,
    input  logic                      reset,

    // Core request and response
    input  logic                      req_valid,
    input  miss_cache_pkg::core_req_t req,
    output logic                      req_stall,
    output logic                      rsp_valid,
    output miss_cache_pkg::core_rsp_t rsp,

    // Memory fill request and return
    output logic                      fill_req_valid,
    output miss_cache_pkg::fill_t     fill_req,
    input  logic                      fill_valid,
    input  miss_cache_pkg::fill_t     fill
);

    logic [NUM_BANKS-1:0]      bank_stop;
    logic [NUM_BANKS-1:0]      bank_req_valid;
    miss_cache_pkg::core_req_t bank_req;
    logic [NUM_BANKS-1:0]      rsp_pend;
    logic [NUM_BANKS-1:0]      rsp_grant;
    logic [NUM_BANKS-1:0]      fill_pend;
    logic [NUM_BANKS-1:0]      fill_grant;
    miss_cache_pkg::core_rsp_t bank_rsp [NUM_BANKS];
    miss_cache_pkg::fill_t     bank_fill [NUM_BANKS];

    req_dispatch #(
        .NUM_BANKS (NUM_BANKS)
    ) i_req_dispatch (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .req_stall      (req_stall),
        .bank_stop      (bank_stop),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req)
    );

    // Fill return goes to every bank, each one filters on its index
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        cache_bank #(
            .BANK_INDEX    (b),
            .NUM_BANKS     (NUM_BANKS),
            .MRVQ_SIZE     (MRVQ_SIZE),
            .SETS_PER_BANK (SETS_PER_BANK)
        ) i_cache_bank (
            .clk        (clk),
            .reset      (reset),
            .req_valid  (bank_req_valid[b]),
            .req        (bank_req),
            .stop       (bank_stop[b]),
            .fill_valid (fill_valid),
            .fill       (fill),
            .rsp_pend   (rsp_pend[b]),
            .rsp        (bank_rsp[b]),
            .rsp_grant  (rsp_grant[b]),
            .fill_pend  (fill_pend[b]),
            .fill_req   (bank_fill[b]),
            .fill_grant (fill_grant[b])
        );
    end

    bank_drain #(
        .NUM_BANKS (NUM_BANKS)
    ) i_bank_drain (
        .clk            (clk),
        .reset          (reset),
        .rsp_pend       (rsp_pend),
        .bank_rsp       (bank_rsp),
        .rsp_grant      (rsp_grant),
        .fill_pend      (fill_pend),
        .bank_fill      (bank_fill),
        .fill_grant     (fill_grant),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .fill_req_valid (fill_req_valid),
        .fill_req       (fill_req)
    );

endmodule

// ==== miss_cache_tb.sv ====
`timescale 1ns/1ns

module miss_cache_tb;

    localparam int NUM_BANKS      = 4;
    localparam int MRVQ_SIZE      = 8;
    localparam int SETS_PER_BANK  = 16;
    localparam int MODEL_SLOTS    = NUM_BANKS * SETS_PER_BANK;
    localparam int TABLE_LEN      = 64;
    localparam int MAX_GAP        = 30;
    localparam int TIMEOUT_CYCLES = TABLE_LEN * (MAX_GAP + 40);
    localparam int LINE_W         = miss_cache_pkg::LINE_ADDR_WIDTH;
    localparam int TAG_W          = miss_cache_pkg::CORE_TAG_WIDTH;
    localparam int SEL_W          = miss_cache_pkg::WORD_SEL_WIDTH;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] line_addr;
        logic              write;
        logic              present;
        int                accept_cyc;
    } expect_t;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      req_valid;
    miss_cache_pkg::core_req_t req;
    logic                      req_stall;
    logic                      rsp_valid;
    miss_cache_pkg::core_rsp_t rsp;
    logic                      fill_req_valid;
    miss_cache_pkg::fill_t     fill_req;
    logic                      fill_valid = 1'b0;
    miss_cache_pkg::fill_t     fill = '0;

    // Stimulus table with fill hold and expected stall columns
    logic [LINE_W-1:0] tbl_line  [TABLE_LEN];
    logic              tbl_write [TABLE_LEN];
    logic [31:0]       tbl_data  [TABLE_LEN];
    int                tbl_gap   [TABLE_LEN];
    logic              tbl_hold  [TABLE_LEN];
    logic              tbl_stall [TABLE_LEN];
    int                tbl_count = 0;

    // Scoreboard, presence model and memory model
    expect_t           exp_q [NUM_BANKS][$];
    int                last_arrival [NUM_BANKS];
    bit                slot_valid [MODEL_SLOTS];
    logic [LINE_W-1:0] slot_line [MODEL_SLOTS];
    bit                fill_expected [65536];
    bit                fill_out [65536];
    int                fills_pending = 0;
    logic [LINE_W-1:0] mem_addr [$];
    int                mem_due [$];
    logic              hold_fills = 1'b0;

    int unsigned lcg_state = 84843;
    int          cyc = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    miss_cache_top #(
        .NUM_BANKS     (NUM_BANKS),
        .MRVQ_SIZE     (MRVQ_SIZE),
        .SETS_PER_BANK (SETS_PER_BANK)
    ) i_miss_cache_top (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .req_stall      (req_stall),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .fill_req_valid (fill_req_valid),
        .fill_req       (fill_req),
        .fill_valid     (fill_valid),
        .fill           (fill)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // Bank bits are the low address bits with the slot bits right above
    function automatic int bank_index(input logic [LINE_W-1:0] line_addr);
        return int'(line_addr) % NUM_BANKS;
    endfunction

    function automatic int model_slot(input logic [LINE_W-1:0] line_addr);
        return int'(line_addr) % MODEL_SLOTS;
    endfunction

    function automatic bit line_present(input logic [LINE_W-1:0] line_addr);
        int s;
        s = model_slot(line_addr);
        return slot_valid[s] && (slot_line[s] == line_addr);
    endfunction

    function automatic bit all_done();
        bit done;
        done = (fills_pending == 0) && (mem_addr.size() == 0);
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (exp_q[b].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        $display("Error counts: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic add_entry(input logic [LINE_W-1:0] line_addr, input logic write,
                             input int gap, input logic hold, input logic stall);
        tbl_line[tbl_count]  = line_addr;
        tbl_write[tbl_count] = write;
        tbl_data[tbl_count]  = lcg_next();
        tbl_gap[tbl_count]   = gap;
        tbl_hold[tbl_count]  = hold;
        tbl_stall[tbl_count] = stall;
        tbl_count++;
    endtask

    task automatic build_table();
        logic [LINE_W-1:0] rnd_line;
        logic              rnd_write;
        int                rnd_gap;
        // Miss, a hit behind it, then misses in the other banks
        add_entry(16'h0010, 1'b0, 0, 1'b0, 1'b0);
        add_entry(16'h0010, 1'b1, 0, 1'b0, 1'b0);
        add_entry(16'h0021, 1'b0, 0, 1'b0, 1'b0);
        add_entry(16'h0032, 1'b1, 0, 1'b0, 1'b0);
        add_entry(16'h0043, 1'b0, 30, 1'b0, 1'b0);
        add_entry(16'h0010, 1'b0, 4, 1'b0, 1'b0);
        add_entry(16'h0021, 1'b1, 4, 1'b0, 1'b0);
        // Same bank and slot as 0x0010, so its fill evicts that line
        add_entry(16'h0050, 1'b0, 30, 1'b0, 1'b0);
        add_entry(16'h0010, 1'b0, 30, 1'b0, 1'b0);
        // Six queued misses on one line raise stop for the seventh
        for (int k = 0; k < 10; k++) begin
            add_entry(16'h0100, 1'(k % 2), 0, (k < 7), (k == 6));
        end
        add_entry(16'h0100, 1'b0, 10, 1'b0, 1'b0);
        // Small line pool so random traffic also hits and evicts
        while (tbl_count < TABLE_LEN) begin
            rnd_line  = LINE_W'(lcg_next() % 128);
            rnd_write = 1'(lcg_next() % 2);
            rnd_gap   = int'(lcg_next() % 7);
            add_entry(rnd_line, rnd_write, rnd_gap, 1'b0, 1'b0);
        end
    endtask

    task automatic record_accept(input int idx);
        expect_t           e;
        int                b;
        logic [LINE_W-1:0] a;
        a            = tbl_line[idx];
        e.tag        = TAG_W'(idx);
        e.line_addr  = a;
        e.write      = tbl_write[idx];
        e.present    = line_present(a);
        e.accept_cyc = cyc + 1;
        b = bank_index(a);
        exp_q[b].push_back(e);
        // A line neither present nor on its way needs exactly one fill
        if (!e.present && !fill_expected[a] && !fill_out[a]) begin
            fill_expected[a] = 1'b1;
            fills_pending++;
        end
    endtask

    task automatic apply_entry(input int idx);
        bit stall_seen;
        stall_seen = 1'b0;
        @(negedge clk);
        req_valid     = 1'b1;
        req.line_addr = tbl_line[idx];
        req.word_sel  = SEL_W'(idx);
        req.write     = tbl_write[idx];
        req.data      = tbl_data[idx];
        req.tag       = TAG_W'(idx);
        #1;
        hold_fills = tbl_hold[idx];
        while (req_stall) begin
            stall_seen = 1'b1;
            // Fills go back to memory once the expected stall showed up
            if (tbl_stall[idx]) begin
                hold_fills = 1'b0;
            end
            @(negedge clk);
            #1;
        end
        record_accept(idx);
        if (tbl_stall[idx]) begin
            check_value("req_stall", 64'd1, 64'(stall_seen));
        end
        if (tbl_gap[idx] > 0) begin
            @(negedge clk);
            req_valid = 1'b0;
            repeat (tbl_gap[idx] - 1) @(negedge clk);
        end
    endtask

    task automatic sample_response();
        expect_t e;
        int      b;
        if (rsp_valid) begin
            b = bank_index(rsp.line_addr);
            if (exp_q[b].size() == 0) begin
                other_errors++;
                $display("Response with tag %0h from bank %0d at %0t has no request waiting",
                         rsp.tag, b, $time);
            end else begin
                e = exp_q[b].pop_front();
                check_value("rsp.tag", 64'(e.tag), 64'(rsp.tag));
                check_value("rsp.line_addr", 64'(e.line_addr), 64'(rsp.line_addr));
                check_value("rsp.write", 64'(e.write), 64'(rsp.write));
                // A direct hit needs the line, an idle bank and a free response register
                if (!(e.present && last_arrival[b] <= e.accept_cyc)) begin
                    check_value("rsp.replay", 64'd1, 64'(rsp.replay));
                end
                last_arrival[b] = cyc;
            end
        end
    endtask

    task automatic sample_fill_request();
        logic [LINE_W-1:0] a;
        if (fill_req_valid) begin
            a = fill_req.line_addr;
            if (!fill_expected[a]) begin
                other_errors++;
                $display("Fill request for line %h at %0t is unexpected or a duplicate",
                         a, $time);
            end else begin
                fill_expected[a] = 1'b0;
                fills_pending--;
            end
            fill_out[a] = 1'b1;
            mem_addr.push_back(a);
            mem_due.push_back(cyc + int'(3 + lcg_next() % 18));
        end
    endtask

    // Returns at most one fill per cycle and picks the oldest due entry
    task automatic drive_fill();
        int pick;
        int s;
        pick       = -1;
        fill_valid = 1'b0;
        if (!hold_fills) begin
            for (int i = 0; i < mem_addr.size(); i++) begin
                if (pick < 0 && mem_due[i] <= cyc) begin
                    pick = i;
                end
            end
        end
        if (pick >= 0) begin
            fill_valid     = 1'b1;
            fill.line_addr = mem_addr[pick];
            s = model_slot(mem_addr[pick]);
            slot_valid[s] = 1'b1;
            slot_line[s]  = mem_addr[pick];
            fill_out[mem_addr[pick]] = 1'b0;
            mem_addr.delete(pick);
            mem_due.delete(pick);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            sample_response();
            sample_fill_request();
            drive_fill();
            if (cyc > TIMEOUT_CYCLES) begin
                other_errors++;
                $display("Timeout after %0d cycles, responses or fills are missing", cyc);
                report_and_finish();
            end
        end
    end

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        #1;
        // Idle outputs straight out of reset
        check_value("rsp_valid", 64'd0, 64'(rsp_valid));
        check_value("fill_req_valid", 64'd0, 64'(fill_req_valid));
        check_value("req_stall", 64'd0, 64'(req_stall));
        for (int i = 0; i < TABLE_LEN; i++) begin
            apply_entry(i);
        end
        @(negedge clk);
        req_valid = 1'b0;
        #1;
        while (!all_done()) begin
            @(negedge clk);
            #1;
        end
        report_and_finish();
    end

endmodule

// ==== miss_cache_top.f ====
miss_cache_pkg.sv
req_dispatch.sv
miss_resrv.sv
cache_bank.sv
bank_drain.sv
miss_cache_top.sv
miss_cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= miss_cache_tb
FILELIST  ?= miss_cache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
